/* verilog.f */
+incdir+sim
rtl/ntt_ctrl_pkg.sv
rtl/ntt_pass_if.sv
rtl/ntt_pass_seq.sv
rtl/ntt_batch_ctrl.sv
rtl/tf_depth_gen.sv
rtl/ntt_ctrl_top.sv
sim/ntt_ctrl_tb.sv

/* Bender.yml */
package:
  name: ntt_ctrl

sources:
  - rtl/ntt_ctrl_pkg.sv
  - rtl/ntt_pass_if.sv
  - rtl/ntt_pass_seq.sv
  - rtl/ntt_batch_ctrl.sv
  - rtl/tf_depth_gen.sv
  - rtl/ntt_ctrl_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/ntt_ctrl_tb.sv

/* sim/ntt_ctrl_ref.svh */
`ifndef NTT_CTRL_REF_SVH
`define NTT_CTRL_REF_SVH

typedef enum {K_RESET, K_IDLE, K_PASS, K_DRAIN, K_FINISH} ref_kind_t;

typedef struct packed {
    logic tf_init_base;
    logic tf_init_const;
    logic tf_ren;
    logic tf_wen;
    logic agu_enable;
    logic agu_enable_k2;
    logic r_enable;
    logic w_enable;
    logic last_stage;
    logic ntt_enable;
    ntt_ctrl_pkg::depth_t it_depth;
} ctrl_out_t;

// model state, advanced once per rising edge
ref_kind_t m_kind;
int m_stage;
int m_init;
int m_bu;
int m_drain;
int m_batch;
int m_group;
int m_agu;
int m_pat;

function automatic void model_reset();
    m_kind = K_RESET;
    m_stage = 0;
    m_init = 0;
    m_bu = 0;
    m_drain = 0;
    m_batch = 0;
    m_group = 0;
    m_agu = 0;
    m_pat = 0;
endfunction

function automatic ctrl_out_t model_step(input logic en, input logic rdy, input logic done);
    ctrl_out_t o;
    int blen;
    o = '0;
    case (m_kind)
        K_IDLE: begin
            o.tf_init_base = 1'b1;
            o.tf_init_const = 1'b1;
        end
        K_PASS: begin
            o.r_enable = en;
            o.tf_ren = en;
            o.w_enable = done;
            o.ntt_enable = rdy;
            o.last_stage = (m_stage == 3);
            o.agu_enable_k2 = (m_stage == 3);
            if (m_stage == 0) begin
                o.agu_enable = (m_agu < ntt_ctrl_pkg::PASS0_AGU_LEN);
            end else begin
                o.agu_enable = (m_stage != 3);
            end
            if (en) begin
                case (m_stage)
                    0: o.it_depth = 8'd0;
                    1: begin
                        o.it_depth = 8'd1;
                        o.tf_wen = (m_batch == ntt_ctrl_pkg::PASS1_BATCH - 1) &&
                                   (m_group < ntt_ctrl_pkg::PASS1_GROUPS - 1);
                    end
                    2: begin
                        o.it_depth = (m_pat < 2) ? 8'd2 : 8'd3;
                        o.tf_wen = (m_group == 1);
                    end
                    default: begin
                        o.it_depth = ntt_ctrl_pkg::LAST_DEPTH;
                        o.tf_wen = (m_bu >= ntt_ctrl_pkg::PASS3_WEN_START);
                    end
                endcase
            end
        end
        K_DRAIN: begin
            o.w_enable = 1'b1;
            o.ntt_enable = rdy;
            o.it_depth = (m_stage == 3) ? ntt_ctrl_pkg::LAST_DEPTH : m_stage[7:0];
        end
        default: begin
            o = '0;
        end
    endcase

    case (m_kind)
        K_RESET: m_kind = K_IDLE;
        K_IDLE: begin
            if (m_init == ntt_ctrl_pkg::POLY_DEGREE) begin
                m_kind = K_PASS;
                m_stage = 0;
                m_init = 0;
                m_agu = 0;
            end else begin
                m_init++;
            end
        end
        K_PASS: begin
            m_agu++;
            if (en) begin
                m_pat = (m_pat + 1) % 4;
                if (m_stage == 1 || m_stage == 2) begin
                    blen = (m_stage == 1) ? ntt_ctrl_pkg::PASS1_BATCH : ntt_ctrl_pkg::PASS2_BATCH;
                    if (m_batch == blen - 1) begin
                        m_batch = 0;
                        m_group++;
                    end else begin
                        m_batch++;
                    end
                end
                if (m_bu == ntt_ctrl_pkg::BU_PER_PASS - 1) begin
                    m_kind = K_DRAIN;
                    m_bu = 0;
                    m_batch = 0;
                    m_group = 0;
                    m_pat = 0;
                    m_drain = 0;
                end else begin
                    m_bu++;
                end
            end
        end
        K_DRAIN: begin
            if (m_drain == ntt_ctrl_pkg::DRAIN_CYCLES) begin
                m_drain = 0;
                if (m_stage == 3) begin
                    m_kind = K_FINISH;
                end else begin
                    m_kind = K_PASS;
                    m_stage++;
                    m_agu = 0;
                end
            end else begin
                m_drain++;
            end
        end
        default: m_kind = m_kind;
    endcase
    return o;
endfunction

task automatic check_bit(input string name, input logic got, input logic exp, input int test);
    checks++;
    if (got !== exp) begin
        $display("CHECK FAILED %s: got %h, expected %h (cycle %0d)", name, got, exp, cycles);
        test_errs[test]++;
    end
endtask

task automatic check_depth(input string name, input ntt_ctrl_pkg::depth_t got,
                           input ntt_ctrl_pkg::depth_t exp, input int test);
    checks++;
    if (got !== exp) begin
        $display("CHECK FAILED %s: got %h, expected %h (cycle %0d)", name, got, exp, cycles);
        test_errs[test]++;
    end
endtask

task automatic check_count(input string name, input ntt_ctrl_pkg::count_t got,
                           input ntt_ctrl_pkg::count_t exp, input int test);
    checks++;
    if (got !== exp) begin
        $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        test_errs[test]++;
    end
endtask

`endif

/* sim/ntt_ctrl_tb.sv */
`timescale 1ns/1ps

module ntt_ctrl_tb;

    logic clk;
    logic rst;
    logic agu_done;
    logic bn_ma_out_en;
    logic r_enable_out;
    logic w_enable_out;
    logic ntt_done;
    logic tf_init_base;
    logic tf_ren;
    logic tf_wen;
    logic tf_init_const;
    logic agu_enable;
    logic agu_enable_k2;
    logic r_enable;
    logic w_enable;
    logic last_stage;
    logic ntt_enable;
    ntt_ctrl_pkg::depth_t it_depth;

    int seed;
    int cycles;
    int checks;
    int test_errs [1:6];
    int total_errs;
    int init_cyc;
    int finish_cyc;
    int pass_len [4];
    int strobe_cnt [4];
    int drain_len [4];
    int wen_cnt [4];
    int agu_cnt [4];
    int k2_cnt;
    int last_cnt;
    int sig_test;
    logic idle_done;
    // roughly three times a run at half strobe density
    int cycle_limit = 3 * (4 + ntt_ctrl_pkg::POLY_DEGREE + 2 +
                           4 * (2 * ntt_ctrl_pkg::BU_PER_PASS + ntt_ctrl_pkg::DRAIN_CYCLES + 1));

    `include "ntt_ctrl_ref.svh"

    ctrl_out_t exp_o;
    ref_kind_t cur_kind;
    int cur_stage;

    ntt_ctrl_top DUT (
        .clk           (clk),
        .rst           (rst),
        .agu_done      (agu_done),
        .bn_ma_out_en  (bn_ma_out_en),
        .r_enable_out  (r_enable_out),
        .w_enable_out  (w_enable_out),
        .ntt_done      (ntt_done),
        .tf_init_base  (tf_init_base),
        .tf_ren        (tf_ren),
        .tf_wen        (tf_wen),
        .tf_init_const (tf_init_const),
        .agu_enable    (agu_enable),
        .agu_enable_k2 (agu_enable_k2),
        .r_enable      (r_enable),
        .w_enable      (w_enable),
        .last_stage    (last_stage),
        .ntt_enable    (ntt_enable),
        .it_depth      (it_depth)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic drive_inputs();
        logic [31:0] rnd;
        rnd = $random(seed);
        bn_ma_out_en = rnd[0];
        r_enable_out = rnd[1];
        ntt_done = rnd[2];
        agu_done = rnd[3];
        w_enable_out = rnd[4];
    endtask

    task automatic check_totals();
        for (int i = 0; i < 4; i++) begin
            check_count($sformatf("pass %0d strobes", i), strobe_cnt[i],
                        ntt_ctrl_pkg::BU_PER_PASS, 2);
            check_count($sformatf("drain %0d w_enable cycles", i), drain_len[i],
                        ntt_ctrl_pkg::DRAIN_CYCLES + 1, 3);
        end
        check_count("pass 0 tf_wen", wen_cnt[0], 0, 5);
        check_count("pass 1 tf_wen", wen_cnt[1], ntt_ctrl_pkg::PASS1_GROUPS - 1, 5);
        check_count("pass 2 tf_wen", wen_cnt[2],
                    ntt_ctrl_pkg::BU_PER_PASS - ntt_ctrl_pkg::PASS2_BATCH, 5);
        check_count("pass 3 tf_wen", wen_cnt[3],
                    ntt_ctrl_pkg::BU_PER_PASS - ntt_ctrl_pkg::PASS3_WEN_START, 5);
        check_count("pass 0 agu_enable", agu_cnt[0], ntt_ctrl_pkg::PASS0_AGU_LEN, 6);
        check_count("pass 1 agu_enable", agu_cnt[1], pass_len[1], 6);
        check_count("pass 2 agu_enable", agu_cnt[2], pass_len[2], 6);
        check_count("pass 3 agu_enable", agu_cnt[3], 0, 6);
        check_count("agu_enable_k2 cycles", k2_cnt, pass_len[3], 6);
        check_count("last_stage cycles", last_cnt, pass_len[3], 6);
    endtask

    task automatic print_result(input int idx, input string title);
        if (test_errs[idx] == 0) begin
            $display("test %0d %s: ok", idx, title);
        end else begin
            $display("test %0d %s: %0d errors", idx, title, test_errs[idx]);
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            #1;
            drive_inputs();
        end
    end

    // expected outputs from the model, compared mid-cycle
    always @(negedge clk) begin
        cycles++;
        if (rst) begin
            model_reset();
        end
        cur_kind = m_kind;
        cur_stage = m_stage;
        exp_o = rst ? '0 : model_step(bn_ma_out_en, r_enable_out, ntt_done);
        if (cur_kind == K_RESET || cur_kind == K_IDLE) begin
            sig_test = 1;
        end else begin
            sig_test = (cur_kind == K_PASS) ? 2 : 3;
        end
        check_bit("tf_init_base", tf_init_base, exp_o.tf_init_base, 1);
        check_bit("tf_init_const", tf_init_const, exp_o.tf_init_const, 1);
        check_bit("r_enable", r_enable, exp_o.r_enable, sig_test);
        check_bit("tf_ren", tf_ren, exp_o.tf_ren, sig_test);
        check_bit("w_enable", w_enable, exp_o.w_enable, sig_test);
        check_bit("ntt_enable", ntt_enable, exp_o.ntt_enable, sig_test);
        check_depth("it_depth", it_depth, exp_o.it_depth, 4);
        check_bit("tf_wen", tf_wen, exp_o.tf_wen, 5);
        check_bit("agu_enable", agu_enable, exp_o.agu_enable, 6);
        check_bit("agu_enable_k2", agu_enable_k2, exp_o.agu_enable_k2, 6);
        check_bit("last_stage", last_stage, exp_o.last_stage, 6);
        init_cyc += tf_init_base;
        if (!rst) begin
            case (cur_kind)
                K_PASS: begin
                    pass_len[cur_stage]++;
                    strobe_cnt[cur_stage] += r_enable;
                    wen_cnt[cur_stage] += tf_wen;
                    agu_cnt[cur_stage] += agu_enable;
                    k2_cnt += agu_enable_k2;
                    last_cnt += last_stage;
                end
                K_DRAIN: drain_len[cur_stage] += w_enable;
                K_FINISH: finish_cyc++;
                default: ;
            endcase
        end
        if (cur_kind == K_IDLE && m_kind == K_PASS) begin
            idle_done = 1'b1;
        end
    end

    initial begin
        wait (cycles > cycle_limit);
        $display("timeout: the finish phase was not reached within %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        seed = 31;
        idle_done = 1'b0;
        agu_done = 1'b0;
        bn_ma_out_en = 1'b0;
        r_enable_out = 1'b0;
        w_enable_out = 1'b0;
        ntt_done = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        wait (idle_done);
        @(posedge clk);
        check_count("idle tf_init_base cycles", init_cyc, ntt_ctrl_pkg::POLY_DEGREE + 1, 1);
        print_result(1, "reset and load wait");

        // a few finish cycles to confirm the outputs stay quiet
        wait (finish_cyc >= 10);
        @(posedge clk);
        check_totals();
        print_result(2, "pass strobes and enables");
        print_result(3, "drains and finish");
        print_result(4, "twiddle depth");
        print_result(5, "twiddle writes");
        print_result(6, "address enables and last stage");

        total_errs = 0;
        for (int t = 1; t <= 6; t++) begin
            total_errs += test_errs[t];
        end
        $display("%0d checks, %0d errors, %0d cycles", checks, total_errs, cycles);
        if (total_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* rtl/ntt_ctrl_top.sv */
`timescale 1ns/1ps

module ntt_ctrl_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 agu_done,
    input  logic                 bn_ma_out_en,
    input  logic                 r_enable_out,
    input  logic                 w_enable_out,
    input  logic                 ntt_done,
    output logic                 tf_init_base,
    output logic                 tf_ren,
    output logic                 tf_wen,
    output logic                 tf_init_const,
    output logic                 agu_enable,
    output logic                 agu_enable_k2,
    output logic                 r_enable,
    output logic                 w_enable,
    output logic                 last_stage,
    output logic                 ntt_enable,
    output ntt_ctrl_pkg::depth_t it_depth
);

    ntt_pass_if pass_bus ();

    ntt_pass_seq u_pass_seq (
        .clk           (clk),
        .rst           (rst),
        .bn_ma_out_en  (bn_ma_out_en),
        .r_enable_out  (r_enable_out),
        .ntt_done      (ntt_done),
        .pass          (pass_bus.seq),
        .r_enable      (r_enable),
        .w_enable      (w_enable),
        .ntt_enable    (ntt_enable),
        .tf_ren        (tf_ren),
        .tf_init_base  (tf_init_base),
        .tf_init_const (tf_init_const),
        .last_stage    (last_stage)
    );

    ntt_batch_ctrl u_batch_ctrl (
        .clk           (clk),
        .rst           (rst),
        .pass          (pass_bus.user),
        .tf_wen        (tf_wen),
        .agu_enable    (agu_enable),
        .agu_enable_k2 (agu_enable_k2)
    );

    tf_depth_gen u_depth_gen (
        .clk      (clk),
        .rst      (rst),
        .pass     (pass_bus.user),
        .it_depth (it_depth)
    );

endmodule

/* rtl/tf_depth_gen.sv */
`timescale 1ns/1ps

module tf_depth_gen (
    input  logic                 clk,
    input  logic                 rst,
    ntt_pass_if.user             pass,
    output ntt_ctrl_pkg::depth_t it_depth
);

    logic [1:0] pat_cnt;
    logic [1:0] pat_next;
    ntt_ctrl_pkg::depth_t depth_q;

    assign pat_next = pat_cnt + 2'd1;

    // 2, 2, 3, 3 over successive pass 2 strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pat_cnt <= '0;
            depth_q <= ntt_ctrl_pkg::PASS2_BASE_DEPTH;
        end else if (pass.phase != ntt_ctrl_pkg::PH_PASS2) begin
            pat_cnt <= '0;
            depth_q <= ntt_ctrl_pkg::PASS2_BASE_DEPTH;
        end else if (pass.op_strobe) begin
            pat_cnt <= pat_next;
            depth_q <= ntt_ctrl_pkg::PASS2_BASE_DEPTH + {7'd0, pat_next[1]};
        end
    end

    always_comb begin
        case (pass.phase)
            ntt_ctrl_pkg::PH_PASS0, ntt_ctrl_pkg::PH_PASS1: begin
                it_depth = pass.op_strobe ? pass.stage_idx : '0;
            end
            ntt_ctrl_pkg::PH_PASS2: begin
                it_depth = pass.op_strobe ? depth_q : '0;
            end
            ntt_ctrl_pkg::PH_PASS3: begin
                it_depth = pass.op_strobe ? ntt_ctrl_pkg::LAST_DEPTH : '0;
            end
            ntt_ctrl_pkg::PH_DRAIN0, ntt_ctrl_pkg::PH_DRAIN1, ntt_ctrl_pkg::PH_DRAIN2: begin
                it_depth = pass.stage_idx;
            end
            ntt_ctrl_pkg::PH_DRAIN3: begin
                it_depth = ntt_ctrl_pkg::LAST_DEPTH;
            end
            default: begin
                it_depth = '0;
            end
        endcase
    end

endmodule

/* rtl/ntt_batch_ctrl.sv */
`timescale 1ns/1ps

module ntt_batch_ctrl (
    input  logic     clk,
    input  logic     rst,
    ntt_pass_if.user pass,
    output logic     tf_wen,
    output logic     agu_enable,
    output logic     agu_enable_k2
);

    ntt_ctrl_pkg::count_t batch_cnt;
    ntt_ctrl_pkg::count_t group_cnt;
    ntt_ctrl_pkg::count_t agu_cnt;
    ntt_ctrl_pkg::count_t batch_len;
    ntt_ctrl_pkg::count_t group_num;

    logic batched;
    logic batch_wrap;

    assign batched = pass.phase inside {ntt_ctrl_pkg::PH_PASS1, ntt_ctrl_pkg::PH_PASS2,
                                        ntt_ctrl_pkg::PH_PASS3};

    always_comb begin
        case (pass.phase)
            ntt_ctrl_pkg::PH_PASS1: begin
                batch_len = ntt_ctrl_pkg::PASS1_BATCH;
                group_num = ntt_ctrl_pkg::PASS1_GROUPS;
            end
            ntt_ctrl_pkg::PH_PASS2: begin
                batch_len = ntt_ctrl_pkg::PASS2_BATCH;
                group_num = ntt_ctrl_pkg::PASS2_GROUPS;
            end
            default: begin
                // pass 3 is a single batch covering the whole pass
                batch_len = ntt_ctrl_pkg::PASS3_BATCH;
                group_num = ntt_ctrl_pkg::BU_PER_PASS / ntt_ctrl_pkg::PASS3_BATCH;
            end
        endcase
    end

    assign batch_wrap = pass.op_strobe && (batch_cnt == batch_len - 8'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            batch_cnt <= '0;
            group_cnt <= '0;
        end else if (!batched) begin
            batch_cnt <= '0;
            group_cnt <= '0;
        end else if (batch_wrap) begin
            batch_cnt <= '0;
            if (group_cnt == group_num - 8'd1) begin
                group_cnt <= '0;
            end else begin
                group_cnt <= group_cnt + 8'd1;
            end
        end else if (pass.op_strobe) begin
            batch_cnt <= batch_cnt + 8'd1;
        end
    end

    // pass 0 window counts cycles, not strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            agu_cnt <= '0;
        end else if (pass.phase != ntt_ctrl_pkg::PH_PASS0) begin
            agu_cnt <= '0;
        end else if (agu_cnt != ntt_ctrl_pkg::PASS0_AGU_LEN) begin
            agu_cnt <= agu_cnt + 8'd1;
        end
    end

    always_comb begin
        tf_wen = 1'b0;
        agu_enable = 1'b0;
        case (pass.phase)
            ntt_ctrl_pkg::PH_PASS0: begin
                agu_enable = (agu_cnt != ntt_ctrl_pkg::PASS0_AGU_LEN);
            end
            ntt_ctrl_pkg::PH_PASS1: begin
                tf_wen = batch_wrap && (group_cnt < ntt_ctrl_pkg::PASS1_GROUPS - 8'd1);
                agu_enable = 1'b1;
            end
            ntt_ctrl_pkg::PH_PASS2: begin
                tf_wen = pass.op_strobe && (group_cnt == 8'd1);
                agu_enable = 1'b1;
            end
            ntt_ctrl_pkg::PH_PASS3: begin
                tf_wen = pass.op_strobe &&
                         (pass.bu_count >= ntt_ctrl_pkg::PASS3_WEN_START);
            end
            default: begin
                tf_wen = 1'b0;
            end
        endcase
    end

    assign agu_enable_k2 = (pass.phase == ntt_ctrl_pkg::PH_PASS3);

    tf_wen_in_pass: assert property (@(posedge clk) disable iff (rst)
        $rose(tf_wen) |-> pass.phase inside {ntt_ctrl_pkg::PH_PASS1,
                                             ntt_ctrl_pkg::PH_PASS2,
                                             ntt_ctrl_pkg::PH_PASS3});

endmodule

/* rtl/ntt_pass_seq.sv */
`timescale 1ns/1ps

module ntt_pass_seq (
    input  logic    clk,
    input  logic    rst,
    input  logic    bn_ma_out_en,
    input  logic    r_enable_out,
    input  logic    ntt_done,
    ntt_pass_if.seq pass,
    output logic    r_enable,
    output logic    w_enable,
    output logic    ntt_enable,
    output logic    tf_ren,
    output logic    tf_init_base,
    output logic    tf_init_const,
    output logic    last_stage
);

    ntt_ctrl_pkg::pass_phase_t phase_q;
    ntt_ctrl_pkg::pass_phase_t phase_d;
    ntt_ctrl_pkg::count_t init_cnt;
    ntt_ctrl_pkg::count_t bu_cnt;
    ntt_ctrl_pkg::count_t drain_cnt;
    ntt_ctrl_pkg::depth_t stage;

    logic in_pass;
    logic in_drain;
    logic strobe;
    logic init_last;
    logic pass_last;
    logic drain_last;

    assign in_pass = phase_q inside {ntt_ctrl_pkg::PH_PASS0, ntt_ctrl_pkg::PH_PASS1,
                                     ntt_ctrl_pkg::PH_PASS2, ntt_ctrl_pkg::PH_PASS3};
    assign in_drain = phase_q inside {ntt_ctrl_pkg::PH_DRAIN0, ntt_ctrl_pkg::PH_DRAIN1,
                                      ntt_ctrl_pkg::PH_DRAIN2, ntt_ctrl_pkg::PH_DRAIN3};

    assign strobe = in_pass && bn_ma_out_en;
    assign init_last = (phase_q == ntt_ctrl_pkg::PH_IDLE) &&
                       (init_cnt == ntt_ctrl_pkg::POLY_DEGREE);
    assign pass_last = strobe && (bu_cnt == ntt_ctrl_pkg::BU_PER_PASS - 8'd1);
    assign drain_last = in_drain && (drain_cnt == ntt_ctrl_pkg::DRAIN_CYCLES);

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            ntt_ctrl_pkg::PH_RESET: begin
                phase_d = ntt_ctrl_pkg::PH_IDLE;
            end
            ntt_ctrl_pkg::PH_IDLE: begin
                if (init_last) begin
                    phase_d = ntt_ctrl_pkg::PH_PASS0;
                end
            end
            ntt_ctrl_pkg::PH_PASS0: begin
                if (pass_last) begin
                    phase_d = ntt_ctrl_pkg::PH_DRAIN0;
                end
            end
            ntt_ctrl_pkg::PH_DRAIN0: begin
                if (drain_last) begin
                    phase_d = ntt_ctrl_pkg::PH_PASS1;
                end
            end
            ntt_ctrl_pkg::PH_PASS1: begin
                if (pass_last) begin
                    phase_d = ntt_ctrl_pkg::PH_DRAIN1;
                end
            end
            ntt_ctrl_pkg::PH_DRAIN1: begin
                if (drain_last) begin
                    phase_d = ntt_ctrl_pkg::PH_PASS2;
                end
            end
            ntt_ctrl_pkg::PH_PASS2: begin
                if (pass_last) begin
                    phase_d = ntt_ctrl_pkg::PH_DRAIN2;
                end
            end
            ntt_ctrl_pkg::PH_DRAIN2: begin
                if (drain_last) begin
                    phase_d = ntt_ctrl_pkg::PH_PASS3;
                end
            end
            ntt_ctrl_pkg::PH_PASS3: begin
                if (pass_last) begin
                    phase_d = ntt_ctrl_pkg::PH_DRAIN3;
                end
            end
            ntt_ctrl_pkg::PH_DRAIN3: begin
                if (drain_last) begin
                    phase_d = ntt_ctrl_pkg::PH_FINISH;
                end
            end
            ntt_ctrl_pkg::PH_FINISH: begin
                phase_d = ntt_ctrl_pkg::PH_FINISH;
            end
            default: begin
                phase_d = ntt_ctrl_pkg::PH_RESET;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_q <= ntt_ctrl_pkg::PH_RESET;
            init_cnt <= '0;
            bu_cnt <= '0;
            drain_cnt <= '0;
        end else begin
            phase_q <= phase_d;
            if (phase_q == ntt_ctrl_pkg::PH_IDLE && !init_last) begin
                init_cnt <= init_cnt + 8'd1;
            end else begin
                init_cnt <= '0;
            end
            // counts hold while the pass is stalled
            if (pass_last || !in_pass) begin
                bu_cnt <= '0;
            end else if (strobe) begin
                bu_cnt <= bu_cnt + 8'd1;
            end
            // shared by all four drains, zero on entry
            if (in_drain && !drain_last) begin
                drain_cnt <= drain_cnt + 8'd1;
            end else begin
                drain_cnt <= '0;
            end
        end
    end

    always_comb begin
        case (phase_q)
            ntt_ctrl_pkg::PH_PASS1, ntt_ctrl_pkg::PH_DRAIN1: stage = 8'd1;
            ntt_ctrl_pkg::PH_PASS2, ntt_ctrl_pkg::PH_DRAIN2: stage = 8'd2;
            ntt_ctrl_pkg::PH_PASS3, ntt_ctrl_pkg::PH_DRAIN3: stage = 8'd3;
            default: stage = 8'd0;
        endcase
    end

    always_comb begin
        r_enable = 1'b0;
        tf_ren = 1'b0;
        w_enable = 1'b0;
        ntt_enable = 1'b0;
        tf_init_base = 1'b0;
        tf_init_const = 1'b0;
        if (in_pass) begin
            r_enable = strobe;
            tf_ren = strobe;
            w_enable = ntt_done;
            ntt_enable = r_enable_out;
        end else if (in_drain) begin
            w_enable = 1'b1;
            ntt_enable = r_enable_out;
        end else if (phase_q == ntt_ctrl_pkg::PH_IDLE) begin
            tf_init_base = 1'b1;
            tf_init_const = 1'b1;
        end
    end

    assign last_stage = (phase_q == ntt_ctrl_pkg::PH_PASS3);

    assign pass.phase = phase_q;
    assign pass.op_strobe = strobe;
    assign pass.bu_count = bu_cnt;
    assign pass.stage_idx = stage;

    finish_sticky: assert property (@(posedge clk) disable iff (rst)
        phase_q == ntt_ctrl_pkg::PH_FINISH |=> phase_q == ntt_ctrl_pkg::PH_FINISH);

    bu_count_bound: assert property (@(posedge clk) disable iff (rst)
        bu_cnt <= ntt_ctrl_pkg::BU_PER_PASS - 8'd1);

endmodule

/* rtl/ntt_pass_if.sv */
`timescale 1ns/1ps

interface ntt_pass_if;

    ntt_ctrl_pkg::pass_phase_t phase;
    // operand accepted in the current pass
    logic op_strobe;
    ntt_ctrl_pkg::count_t bu_count;
    ntt_ctrl_pkg::depth_t stage_idx;

    modport seq (
        output phase,
        output op_strobe,
        output bu_count,
        output stage_idx
    );

    modport user (
        input phase,
        input op_strobe,
        input bu_count,
        input stage_idx
    );

endinterface

/* rtl/ntt_ctrl_pkg.sv */
package ntt_ctrl_pkg;

    typedef enum logic [3:0] {
        PH_RESET,
        PH_IDLE,
        PH_PASS0,
        PH_PASS1,
        PH_PASS2,
        PH_PASS3,
        PH_DRAIN0,
        PH_DRAIN1,
        PH_DRAIN2,
        PH_DRAIN3,
        PH_FINISH
    } pass_phase_t;

    typedef logic [7:0] depth_t;
    typedef logic [7:0] count_t;

    // coefficient memory load wait
    localparam count_t POLY_DEGREE = 8'd32;

    localparam count_t BU_PER_PASS = 8'd32;
    localparam count_t DRAIN_CYCLES = 8'd12;
    localparam count_t PASS0_AGU_LEN = 8'd8;

    localparam count_t PASS1_BATCH = 8'd2;
    localparam count_t PASS1_GROUPS = 8'd16;
    localparam count_t PASS2_BATCH = 8'd16;
    localparam count_t PASS2_GROUPS = 8'd2;
    localparam count_t PASS3_BATCH = 8'd32;
    localparam count_t PASS3_WEN_START = 8'd2;

    // pass 2 alternates between this depth and the next one up
    localparam depth_t PASS2_BASE_DEPTH = 8'd2;
    localparam depth_t LAST_DEPTH = 8'd4;

endpackage
